// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - design/rv32i_pkg.sv
      - design/ex_mem_reg.sv
      - design/byte_lane_ram.sv
      - design/mem_wb_reg.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - verif/mem_stage_assertions.sv
      - verif/mem_stage_tb.sv

// ==== compile.f ====
design/rv32i_pkg.sv
design/ex_mem_reg.sv
design/byte_lane_ram.sv
design/mem_wb_reg.sv
design/mem_stage_top.sv
verif/mem_stage_assertions.sv
verif/mem_stage_tb.sv

// ==== design/byte_lane_ram.sv ====
module byte_lane_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(MEM_WORDS)-1:0] addr,
    input  logic                         we,
    input  logic [7:0]                   wdata,
    output logic [7:0]                   q
);
    // one byte of every data word
    logic [7:0] mem [MEM_WORDS];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read returns old data on a same-address write
    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

// ==== design/ex_mem_reg.sv ====
module ex_mem_reg #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv32i_pkg::ex_result_t        ex,
    output rv32i_pkg::stage_t            stage,
    output logic [3:0]                   mem_byte_enable,
    output logic                         mem_write,
    output logic [$clog2(MEM_WORDS)-1:0] word_addr,
    output logic [31:0]                  store_data,
    output rv32i_pkg::pcmux_sel_t        pcmux_sel,
    output logic                         br_taken
);
    import rv32i_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    stage_t      stage_q;
    logic [31:0] rs2_q;
    logic [1:0]  offset;

    // offset 3 halfwords wrap back to the low half
    function automatic logic [3:0] half_enable(input logic [1:0] off);
        case (off)
            2'b00:   return 4'b0011;
            2'b01:   return 4'b0110;
            2'b10:   return 4'b1100;
            default: return 4'b0011;
        endcase
    endfunction

    function automatic logic [3:0] byte_enable(input logic [1:0] off);
        return 4'b0001 << off;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '0;
        end else begin
            stage_q.ctrl  <= ex.ctrl;
            stage_q.alu   <= ex.alu;
            stage_q.pc    <= ex.pc;
            stage_q.br_en <= ex.br_en;
        end
    end

    // store operand for the byte lanes
    always_ff @(posedge clk) begin
        rs2_q <= ex.rs2;
    end

    assign offset     = stage_q.alu[1:0];
    assign word_addr  = stage_q.alu[ADDR_W+1:2];
    assign mem_write  = (stage_q.ctrl.opcode == op_store);
    assign store_data = rs2_q << {offset, 3'b000};

    // byte enables decoded from the latched address of the same instruction
    always_comb begin
        mem_byte_enable = 4'b1111;
        case (stage_q.ctrl.opcode)
            op_load: begin
                case (load_funct3_t'(stage_q.ctrl.funct3))
                    lw:       mem_byte_enable = 4'b1111;
                    lh, lhu:  mem_byte_enable = half_enable(offset);
                    lb, lbu:  mem_byte_enable = byte_enable(offset);
                    default:  mem_byte_enable = 4'b1111;
                endcase
            end
            op_store: begin
                case (store_funct3_t'(stage_q.ctrl.funct3))
                    sw:      mem_byte_enable = 4'b1111;
                    sh:      mem_byte_enable = half_enable(offset);
                    sb:      mem_byte_enable = byte_enable(offset);
                    default: mem_byte_enable = 4'b1111;
                endcase
            end
            default: mem_byte_enable = 4'b1111;
        endcase
    end

    // jumps always redirect the next pc
    always_comb begin
        pcmux_sel = stage_q.ctrl.pcmux_sel;
        br_taken  = 1'b0;
        case (stage_q.ctrl.opcode)
            op_br: begin
                pcmux_sel = stage_q.br_en ? alu_out : pc_plus4;
                br_taken  = stage_q.br_en;
            end
            op_jal: begin
                pcmux_sel = alu_out;
                br_taken  = 1'b1;
            end
            op_jalr: begin
                pcmux_sel = alu_mod2;
                br_taken  = 1'b1;
            end
            default: ;
        endcase
    end

    assign stage = stage_q;

endmodule

// ==== design/mem_stage_top.sv ====
module mem_stage_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32i_pkg::ex_result_t ex,
    output rv32i_pkg::wb_t        wb,
    output rv32i_pkg::pcmux_sel_t pcmux_sel,
    output logic                  br_taken
);
    import rv32i_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    stage_t            stage;
    logic [3:0]        mem_byte_enable;
    logic              mem_write;
    logic [ADDR_W-1:0] word_addr;
    logic [31:0]       store_data;
    logic [3:0]        lane_we;
    logic [31:0]       lane_q;

    ex_mem_reg #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ex_mem (
        .clk             (clk),
        .rst             (rst),
        .ex              (ex),
        .stage           (stage),
        .mem_byte_enable (mem_byte_enable),
        .mem_write       (mem_write),
        .word_addr       (word_addr),
        .store_data      (store_data),
        .pcmux_sel       (pcmux_sel),
        .br_taken        (br_taken)
    );

    // one lane per byte of the data word
    for (genvar k = 0; k < 4; k++) begin : g_lane
        assign lane_we[k] = mem_write & mem_byte_enable[k];

        byte_lane_ram #(
            .MEM_WORDS(MEM_WORDS)
        ) u_lane (
            .clk   (clk),
            .addr  (word_addr),
            .we    (lane_we[k]),
            .wdata (store_data[8*k +: 8]),
            .q     (lane_q[8*k +: 8])
        );
    end

    mem_wb_reg u_mem_wb (
        .clk    (clk),
        .rst    (rst),
        .stage  (stage),
        .lane_q (lane_q),
        .wb     (wb)
    );

endmodule

// ==== design/mem_wb_reg.sv ====
module mem_wb_reg (
    input  logic              clk,
    input  logic              rst,
    input  rv32i_pkg::stage_t stage,
    input  logic [31:0]       lane_q,
    output rv32i_pkg::wb_t    wb
);
    import rv32i_pkg::*;

    stage_t      stage_q;
    logic [1:0]  offset;
    logic [1:0]  half_off;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] load_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '0;
        end else begin
            stage_q <= stage;
        end
    end

    assign offset = stage_q.alu[1:0];

    // halfword at offset 3 reads the low half, matching the enable rule
    assign half_off = (offset == 2'b11) ? 2'b00 : offset;

    assign sel_byte = lane_q[8*offset +: 8];
    assign sel_half = lane_q[8*half_off +: 16];

    // extension per load width
    always_comb begin
        case (load_funct3_t'(stage_q.ctrl.funct3))
            lb:      load_data = {{24{sel_byte[7]}}, sel_byte};
            lbu:     load_data = {24'h000000, sel_byte};
            lh:      load_data = {{16{sel_half[15]}}, sel_half};
            lhu:     load_data = {16'h0000, sel_half};
            lw:      load_data = lane_q;
            default: load_data = lane_q;
        endcase
    end

    // write-back source
    always_comb begin
        case (stage_q.ctrl.opcode)
            op_load:          wb.data = load_data;
            op_jal, op_jalr:  wb.data = stage_q.pc + 32'd4;
            default:          wb.data = stage_q.alu;
        endcase
        wb.rd    = stage_q.ctrl.rd;
        wb.valid = stage_q.ctrl.load_regfile;
    end

endmodule

// ==== design/rv32i_pkg.sv ====
package rv32i_pkg;

    // rv32i major opcodes, low seven bits of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // load widths, bit 2 marks the unsigned forms
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // next-pc source for the fetch stage
    typedef enum logic [1:0] {
        pc_plus4 = 2'b00,
        alu_out  = 2'b01,
        alu_mod2 = 2'b10
    } pcmux_sel_t;

    // control bits carried down the pipe with each instruction
    typedef struct packed {
        opcode_t     opcode;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic        load_regfile;
        pcmux_sel_t  pcmux_sel;
    } ctrl_word_t;

    // everything the execute stage hands over
    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] alu;
        logic [31:0] rs2;
        logic [31:0] pc;
        logic        br_en;
    } ex_result_t;

    // per-instruction state kept past the memory stage
    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] alu;
        logic [31:0] pc;
        logic        br_en;
    } stage_t;

    // register file write port
    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  rd;
        logic        valid;
    } wb_t;

endpackage

// ==== verif/mem_stage_assertions.sv ====
module mem_stage_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic [3:0]            lane_we,
    input rv32i_pkg::stage_t     stage,
    input rv32i_pkg::wb_t        wb,
    input rv32i_pkg::pcmux_sel_t pcmux_sel,
    input logic                  br_taken
);
    import rv32i_pkg::*;

    // lanes are written only by a latched store, one strobe per byte stored
    a_we_store: assert property (@(posedge clk) disable iff (rst)
        |lane_we |-> stage.ctrl.opcode == op_store &&
            $countones(lane_we) == ((stage.ctrl.funct3 == sb) ? 1 :
                                    (stage.ctrl.funct3 == sh) ? 2 : 4))
        else $error("lane write strobes do not match the latched store");

    // any redirect must be flagged as taken
    a_redirect_taken: assert property (@(posedge clk) disable iff (rst)
        pcmux_sel != pc_plus4 |-> br_taken)
        else $error("pc redirect without br_taken");

    // stores and branches never write the register file
    a_no_wb: assert property (@(posedge clk) disable iff (rst)
        stage.ctrl.opcode inside {op_store, op_br} |=> !wb.valid)
        else $error("write-back raised for a store or branch");

endmodule

bind mem_stage_top mem_stage_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .lane_we   (lane_we),
    .stage     (stage),
    .wb        (wb),
    .pcmux_sel (pcmux_sel),
    .br_taken  (br_taken)
);

// ==== verif/mem_stage_cases.txt ====
# opcode funct3 rd load_regfile alu rs2 pc br_en, then expected wb_data wb_valid pcmux_sel br_taken
# all fields hex, one instruction per line, issued back to back
23 2 00 0 00000040 deadbeef 00000000 0 00000000 0 0 0
23 2 00 0 00000044 11223344 00000000 0 00000000 0 0 0
03 2 05 1 00000040 00000000 00000000 0 deadbeef 1 0 0
23 2 00 0 00000080 8899aabb 00000000 0 00000000 0 0 0
23 0 00 0 00000083 ffffff44 00000000 0 00000000 0 0 0
23 0 00 0 00000082 ffffff33 00000000 0 00000000 0 0 0
03 2 06 1 00000080 00000000 00000000 0 4433aabb 1 0 0
23 0 00 0 00000081 ffffff22 00000000 0 00000000 0 0 0
23 0 00 0 00000080 ffffff11 00000000 0 00000000 0 0 0
03 2 06 1 00000080 00000000 00000000 0 44332211 1 0 0
23 1 00 0 00000080 ffff5566 00000000 0 00000000 0 0 0
23 1 00 0 00000081 ffff7788 00000000 0 00000000 0 0 0
23 1 00 0 00000082 ffff1234 00000000 0 00000000 0 0 0
03 2 07 1 00000080 00000000 00000000 0 12348866 1 0 0
23 1 00 0 00000083 0000abcd 00000000 0 00000000 0 0 0
03 2 07 1 00000080 00000000 00000000 0 12340000 1 0 0
23 2 00 0 00000048 807f01ff 00000000 0 00000000 0 0 0
03 0 08 1 00000048 00000000 00000000 0 ffffffff 1 0 0
03 0 08 1 00000049 00000000 00000000 0 00000001 1 0 0
03 0 08 1 0000004a 00000000 00000000 0 0000007f 1 0 0
03 0 08 1 0000004b 00000000 00000000 0 ffffff80 1 0 0
03 4 09 1 00000048 00000000 00000000 0 000000ff 1 0 0
03 4 09 1 0000004b 00000000 00000000 0 00000080 1 0 0
03 1 0a 1 00000048 00000000 00000000 0 000001ff 1 0 0
03 1 0a 1 00000049 00000000 00000000 0 00007f01 1 0 0
03 1 0a 1 0000004a 00000000 00000000 0 ffff807f 1 0 0
03 1 0a 1 0000004b 00000000 00000000 0 000001ff 1 0 0
03 5 0b 1 0000004a 00000000 00000000 0 0000807f 1 0 0
03 5 0b 1 0000004b 00000000 00000000 0 000001ff 1 0 0
13 0 03 1 00001234 00000000 00000000 0 00001234 1 0 0
37 0 04 1 abcde000 00000000 00000000 0 abcde000 1 0 0
6f 0 01 1 00000200 00000000 00000100 0 00000104 1 1 1
67 0 01 1 00000301 00000000 00000180 0 00000184 1 2 1
63 0 00 0 00000120 00000000 00000110 1 00000000 0 1 1
63 1 00 0 00000140 00000000 00000114 0 00000000 0 0 0

// ==== verif/mem_stage_tb.sv ====
module mem_stage_tb;
    import rv32i_pkg::*;

    // one line of the cases file, stimulus plus expected results
    typedef struct packed {
        ex_result_t  ex;
        logic [31:0] exp_data;
        logic        exp_valid;
        pcmux_sel_t  exp_pc;
        logic        exp_br;
    } case_t;

    logic       clk;
    logic       rst;
    ex_result_t ex;
    wb_t        wb;
    pcmux_sel_t pcmux_sel;
    logic       br_taken;

    case_t cases[$];
    // slot 0 is the reset test, cases start at 1
    bit    fail_flag[];
    int    pend_pc[$];
    int    pend_wb[$];
    int    pass_cnt;
    int    fail_cnt;
    int    cycles;
    int    limit;
    int    n;

    mem_stage_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .ex        (ex),
        .wb        (wb),
        .pcmux_sel (pcmux_sel),
        .br_taken  (br_taken)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int load_cases();
        int          fd;
        string       line;
        logic [31:0] col [12];
        case_t       c;
        fd = $fopen("verif/mem_stage_cases.txt", "r");
        if (fd == 0) begin
            return -1;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                        col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10],
                        col[11]) != 12) begin
                $display("malformed line in cases file: %s", line);
                return -1;
            end
            c = '0;
            c.ex.ctrl.opcode       = opcode_t'(col[0][6:0]);
            c.ex.ctrl.funct3       = col[1][2:0];
            c.ex.ctrl.rd           = col[2][4:0];
            c.ex.ctrl.load_regfile = col[3][0];
            c.ex.ctrl.pcmux_sel    = pc_plus4;
            c.ex.alu               = col[4];
            c.ex.rs2               = col[5];
            c.ex.pc                = col[6];
            c.ex.br_en             = col[7][0];
            c.exp_data             = col[8];
            c.exp_valid            = col[9][0];
            c.exp_pc               = pcmux_sel_t'(col[10][1:0]);
            c.exp_br               = col[11][0];
            cases.push_back(c);
        end
        $fclose(fd);
        return cases.size();
    endfunction

    function automatic void check_val(input int idx, input string name,
                                      input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_flag[idx] = 1'b1;
        end
    endfunction

    function automatic void finish_case(input int idx, input string label);
        if (fail_flag[idx]) begin
            fail_cnt++;
            $display("%s: failed", label);
        end else begin
            pass_cnt++;
            $display("%s: ok", label);
        end
    endfunction

    function automatic void check_idle();
        check_val(0, "wb.valid", 32'd0, wb.valid);
        check_val(0, "pcmux_sel", pc_plus4, pcmux_sel);
        check_val(0, "br_taken", 32'd0, br_taken);
    endfunction

    task automatic run_reset();
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        rst = 1'b0;
        // first cycle out of reset, bubble still in the pipe
        @(negedge clk);
        check_idle();
        finish_case(0, "reset");
    endtask

    task automatic run_cases();
        int    idx;
        case_t c;
        for (int t = 0; t < n + 2; t++) begin
            // write-back of the case issued two falling edges ago
            if (pend_wb.size() > 0) begin
                idx = pend_wb.pop_front();
                c = cases[idx - 1];
                check_val(idx, "wb.valid", c.exp_valid, wb.valid);
                if (c.exp_valid) begin
                    check_val(idx, "wb.data", c.exp_data, wb.data);
                    check_val(idx, "wb.rd", c.ex.ctrl.rd, wb.rd);
                end
                finish_case(idx, $sformatf("case %0d opcode %02h", idx, c.ex.ctrl.opcode));
            end
            // next-pc outputs lag one cycle
            if (pend_pc.size() > 0) begin
                idx = pend_pc.pop_front();
                c = cases[idx - 1];
                check_val(idx, "pcmux_sel", c.exp_pc, pcmux_sel);
                check_val(idx, "br_taken", c.exp_br, br_taken);
                pend_wb.push_back(idx);
            end
            if (t < n) begin
                ex = cases[t].ex;
                pend_pc.push_back(t + 1);
            end else begin
                ex = '0;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        rst      = 1'b1;
        ex       = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        n = load_cases();
        if (n <= 0) begin
            $display("no cases could be loaded from verif/mem_stage_cases.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            limit = 2 * n + 20;
            fail_flag = new[n + 1];
            run_reset();
            run_cases();
            $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule
